// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = desAccelTb
FILELIST = desAccel.f

OBJDIR = obj_dir
SIM = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, a header or the file list changes.
$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

// ==== desAccel.f ====
+incdir+rtl
rtl/desPkg.sv
rtl/desHostRegs.sv
rtl/desKeySchedule.sv
rtl/desBlockState.sv
rtl/desRoundFunction.sv
rtl/desAccel.sv
test/desAccelTb.sv

// ==== rtl/desAccel.sv ====
// Top level of the DES accelerator: register file, key schedule, block state, round function.
`timescale 1ns/1ps
`include "desAccel_cfg.svh"

module desAccel
	import desPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic RD,
	input logic WR,
	input regAddrT Addr,
	input busWordT DataIn,
	output busWordT DataOut
);

	logic start;
	logic ready;
	logic done;
	blockT key;
	blockT plainText;
	blockT result;
	roundCtrlT roundCtrl;
	halfBlockT rightHalf;
	halfBlockT fOut;
	subkeyT subkey;

	desHostRegs hostRegs (
		.Clk(Clk),
		.rstN(rstN),
		.RD(RD),
		.WR(WR),
		.Addr(Addr),
		.DataIn(DataIn),
		.DataOut(DataOut),
		.ready(ready),
		.done(done),
		.result(result),
		.start(start),
		.key(key),
		.plainText(plainText)
	);

	// The key schedule and the block state step in lockstep off the same start.
	desKeySchedule keySchedule (
		.Clk(Clk),
		.rstN(rstN),
		.start(start),
		.key(key),
		.roundCtrl(roundCtrl),
		.subkey(subkey)
	);

	desBlockState blockState (
		.Clk(Clk),
		.rstN(rstN),
		.start(start),
		.plainText(plainText),
		.fOut(fOut),
		.rightHalf(rightHalf),
		.roundCtrl(roundCtrl),
		.ready(ready),
		.done(done),
		.result(result)
	);

	desRoundFunction roundFunction (
		.rightHalf(rightHalf),
		.subkey(subkey),
		.fOut(fOut)
	);

endmodule

// ==== rtl/desAccel_cfg.svh ====
// Width, register slot and round count macros for the DES accelerator.
`ifndef DES_ACCEL_CFG_SVH
`define DES_ACCEL_CFG_SVH

// Bus and register select widths.
`define DES_BUS_WIDTH 32
`define DES_ADDR_WIDTH 2

// A data block and the key are both 64 bits wide.
`define DES_BLOCK_WIDTH 64

`define DES_ROUNDS 16

// Register slots, selected by the low two address bits.
`define DES_REG_DATA 0
`define DES_REG_KEY 1
`define DES_REG_START 2
`define DES_REG_STATUS 3

`endif

// ==== rtl/desBlockState.sv ====
// DES block state: round counter, L and R registers, IP and FP, ready and done.
`timescale 1ns/1ps
`include "desAccel_cfg.svh"

module desBlockState
	import desPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic start,
	input blockT plainText,
	input halfBlockT fOut,
	output halfBlockT rightHalf,
	output roundCtrlT roundCtrl,
	output logic ready,
	output logic done,
	output blockT result
);

	localparam int ipTable [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

	// Inverse of the initial permutation.
	localparam int fpTable [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};

	localparam roundIdxT lastRound = roundIdxT'(`DES_ROUNDS-1);

	halfBlockT lHalf;
	halfBlockT rHalf;
	blockT ipOut;
	roundIdxT roundIdx;
	logic busy;

	function automatic blockT permute64(input blockT x, input int tab [64]);
		blockT y;
		for (int i = 0; i < 64; i++)
		begin
			y[63-i] = x[64-tab[i]];
		end
		return y;
	endfunction

	assign ipOut = permute64(plainText, ipTable);

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			roundIdx <= '0;
			lHalf <= '0;
			rHalf <= '0;
		end
		else if (start)
		begin
			// A start also aborts a run in flight.
			busy <= 1'b1;
			done <= 1'b0;
			roundIdx <= '0;
			lHalf <= ipOut[63:32];
			rHalf <= ipOut[31:0];
		end
		else
		begin
			done <= busy && (roundIdx == lastRound);
			if (busy)
			begin
				lHalf <= rHalf;
				rHalf <= lHalf ^ fOut;
				roundIdx <= roundIdx + roundIdxT'(1);
				if (roundIdx == lastRound)
				begin
					busy <= 1'b0;
				end
			end
		end
	end

	assign ready = ~busy;
	assign rightHalf = rHalf;
	assign roundCtrl.advance = busy;
	assign roundCtrl.roundIdx = roundIdx;

	// The last round leaves the halves unswapped, so FP takes R before L.
	assign result = permute64({rHalf, lHalf}, fpTable);

endmodule

// ==== rtl/desHostRegs.sv ====
// Bus register file of the DES accelerator: data and key shifting, start strobe, read mux.
`timescale 1ns/1ps
`include "desAccel_cfg.svh"

module desHostRegs
	import desPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic RD,
	input logic WR,
	input regAddrT Addr,
	input busWordT DataIn,
	output busWordT DataOut,
	input logic ready,
	input logic done,
	input blockT result,
	output logic start,
	output blockT key,
	output blockT plainText
);

	logic dataSel;
	logic keySel;
	logic statusSel;
	blockT dataReg;
	blockT keyReg;

	assign dataSel = (Addr == regAddrT'(`DES_REG_DATA));
	assign keySel = (Addr == regAddrT'(`DES_REG_KEY));
	assign statusSel = (Addr == regAddrT'(`DES_REG_STATUS));

	// START is a pure strobe and holds no state.
	assign start = WR && (Addr == regAddrT'(`DES_REG_START));

	assign key = keyReg;
	assign plainText = dataReg;

	// Key words enter at the top and push the older word down.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			keyReg <= '0;
		end
		else if (WR && keySel)
		begin
			keyReg <= {DataIn, keyReg[`DES_BLOCK_WIDTH-1:`DES_BUS_WIDTH]};
		end
	end

	// Bus access to DATA takes priority over the result copy.
	// A read moves the upper word down so that two reads return the whole block.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			dataReg <= '0;
		end
		else if (WR && dataSel)
		begin
			dataReg <= {DataIn, dataReg[`DES_BLOCK_WIDTH-1:`DES_BUS_WIDTH]};
		end
		else if (RD && dataSel)
		begin
			dataReg[`DES_BUS_WIDTH-1:0] <= dataReg[`DES_BLOCK_WIDTH-1:`DES_BUS_WIDTH];
		end
		else if (done)
		begin
			dataReg <= result;
		end
	end

	// Unselected slots and idle cycles read as zero.
	always_comb
	begin
		DataOut = '0;
		if (RD && dataSel)
		begin
			DataOut = dataReg[`DES_BUS_WIDTH-1:0];
		end
		else if (RD && statusSel)
		begin
			DataOut = busWordT'(ready);
		end
	end

endmodule

// ==== rtl/desKeySchedule.sv ====
// DES key schedule: PC-1 load, per-round rotation of C and D, PC-2 subkey selection.
`timescale 1ns/1ps
`include "desAccel_cfg.svh"

module desKeySchedule
	import desPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic start,
	input blockT key,
	input roundCtrlT roundCtrl,
	output subkeyT subkey
);

	// Tables use the standard numbering, where bit 1 is the leftmost bit.
	localparam int pc1Table [56] = '{
		57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};

	localparam int pc2Table [48] = '{
		14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

	// A set bit means the halves rotate by two in that round, else by one.
	localparam logic [`DES_ROUNDS-1:0] doubleShift = 16'h7EFC;

	keyHalfT cHalf;
	keyHalfT dHalf;
	logic [55:0] pc1Out;
	logic [55:0] cdHalves;
	roundIdxT nextIdx;

	function automatic keyHalfT rotateLeft(input keyHalfT x, input logic byTwo);
		keyHalfT y;
		if (byTwo)
		begin
			y = {x[25:0], x[27:26]};
		end
		else
		begin
			y = {x[26:0], x[27]};
		end
		return y;
	endfunction

	always_comb
	begin
		for (int i = 0; i < 56; i++)
		begin
			pc1Out[55-i] = key[64-pc1Table[i]];
		end
	end

	assign cdHalves = {cHalf, dHalf};

	// The subkey follows the halves, so it is valid for the whole round.
	always_comb
	begin
		for (int i = 0; i < 48; i++)
		begin
			subkey[47-i] = cdHalves[56-pc2Table[i]];
		end
	end

	assign nextIdx = roundCtrl.roundIdx + roundIdxT'(1);

	// The start edge already applies the round-0 rotation.
	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cHalf <= '0;
			dHalf <= '0;
		end
		else if (start)
		begin
			cHalf <= rotateLeft(pc1Out[55:28], doubleShift[0]);
			dHalf <= rotateLeft(pc1Out[27:0], doubleShift[0]);
		end
		else if (roundCtrl.advance && roundCtrl.roundIdx != roundIdxT'(`DES_ROUNDS-1))
		begin
			cHalf <= rotateLeft(cHalf, doubleShift[nextIdx]);
			dHalf <= rotateLeft(dHalf, doubleShift[nextIdx]);
		end
	end

endmodule

// ==== rtl/desPkg.sv ====
// Vector types and the round control struct shared by the DES accelerator.
`include "desAccel_cfg.svh"

package desPkg;

	typedef logic [`DES_BUS_WIDTH-1:0] busWordT;
	typedef logic [`DES_ADDR_WIDTH-1:0] regAddrT;

	// A data block or a key.
	typedef logic [`DES_BLOCK_WIDTH-1:0] blockT;

	// One Feistel half.
	typedef logic [`DES_BLOCK_WIDTH/2-1:0] halfBlockT;

	// Round subkey after PC-2, and one C or D half after PC-1.
	typedef logic [47:0] subkeyT;
	typedef logic [27:0] keyHalfT;

	typedef logic [$clog2(`DES_ROUNDS)-1:0] roundIdxT;

	// Tells the key schedule that round roundIdx is being computed.
	typedef struct packed
	{
		logic advance;
		roundIdxT roundIdx;
	} roundCtrlT;

endpackage

// ==== rtl/desRoundFunction.sv ====
// DES round function: expansion, subkey mixing, the eight S-boxes and the P permutation.
`timescale 1ns/1ps
`include "desAccel_cfg.svh"

module desRoundFunction
	import desPkg::*;
(
	input halfBlockT rightHalf,
	input subkeyT subkey,
	output halfBlockT fOut
);

	localparam int halfWidth = `DES_BLOCK_WIDTH / 2;

	localparam int eTable [48] = '{
		32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

	localparam int pTable [32] = '{
		16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};

	// Each box holds four rows of sixteen nibbles, row 0 column 0 in the top nibble.
	localparam logic [255:0] sBoxTable [8] = '{
		{64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
			64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D},
		{64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
			64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9},
		{64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
			64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C},
		{64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
			64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E},
		{64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
			64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453},
		{64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
			64'h9EF528C3704A1DB6, 64'h432C95FABE17608D},
		{64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
			64'h14BDC37EAF680592, 64'h6BD814A7950FE23C},
		{64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
			64'h7B419CE206ADF358, 64'h21E74A8DFC90356B}};

	logic [47:0] expanded;
	logic [47:0] mixed;
	halfBlockT sOut;

	always_comb
	begin
		for (int i = 0; i < 48; i++)
		begin
			expanded[47-i] = rightHalf[halfWidth-eTable[i]];
		end
	end

	assign mixed = expanded ^ subkey;

	// The outer two bits of a group pick the row, the inner four the column.
	always_comb
	begin
		logic [5:0] group;
		int entry;
		for (int b = 0; b < 8; b++)
		begin
			group = mixed[47-6*b -: 6];
			entry = {group[5], group[0], group[4:1]};
			sOut[31-4*b -: 4] = sBoxTable[b][255-4*entry -: 4];
		end
	end

	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			fOut[31-i] = sOut[halfWidth-pTable[i]];
		end
	end

endmodule

// ==== test/desAccelTb.sv ====
// Directed testbench for the DES accelerator with bus tasks, LFSR stimulus and known-answer tests.
`timescale 1ns/1ps
`include "desAccel_cfg.svh"

module desAccelTb
	import desPkg::*;
();

	logic Clk;
	logic rstN;
	logic RD;
	logic WR;
	regAddrT Addr;
	busWordT DataIn;
	busWordT DataOut;
	logic [31:0] lfsrState;

	desAccel DUT (
		.Clk(Clk),
		.rstN(rstN),
		.RD(RD),
		.WR(WR),
		.Addr(Addr),
		.DataIn(DataIn),
		.DataOut(DataOut)
	);

	initial
	begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// Fibonacci LFSR with taps 32, 22, 2 and 1; one step yields one bit.
	function automatic logic lfsrStep();
		logic feedback;
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		return feedback;
	endfunction

	function automatic blockT randomBlock();
		blockT value;
		value = '0;
		for (int i = 0; i < 64; i++)
		begin
			value = {value[62:0], lfsrStep()};
		end
		return value;
	endfunction

	task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Stopping at the first mismatch.");
		end
	endtask

	// The DUT samples the write at the second edge.
	// Nothing is read during a write, so the bus must return zero.
	task automatic busWrite(input regAddrT addr, input busWordT data);
		@(posedge Clk);
		WR <= 1'b1;
		Addr <= addr;
		DataIn <= data;
		@(negedge Clk);
		checkEq(DataOut, 64'h0, "DataOut while RD is low");
		@(posedge Clk);
		WR <= 1'b0;
	endtask

	// Read data is combinational, so it is taken at the falling edge.
	task automatic busRead(input regAddrT addr, output busWordT data);
		@(posedge Clk);
		RD <= 1'b1;
		Addr <= addr;
		@(negedge Clk);
		data = DataOut;
		@(posedge Clk);
		RD <= 1'b0;
	endtask

	// Low word first, as the shifting registers expect.
	task automatic writeBlock(input regAddrT addr, input blockT value);
		busWrite(addr, value[31:0]);
		busWrite(addr, value[63:32]);
	endtask

	task automatic readResult(output blockT value);
		busWordT lowWord;
		busWordT highWord;
		busRead(regAddrT'(`DES_REG_DATA), lowWord);
		busRead(regAddrT'(`DES_REG_DATA), highWord);
		value = {highWord, lowWord};
	endtask

	task automatic waitReady();
		busWordT status;
		int polls;
		status = '0;
		polls = 0;
		while (status[0] !== 1'b1)
		begin
			if (polls == 100)
			begin
				$display("Timeout: ready never rose after 100 polls of STATUS.");
				$display("TEST FAILED");
				$fatal(1, "Engine did not finish.");
			end
			busRead(regAddrT'(`DES_REG_STATUS), status);
			polls++;
		end
	endtask

	task automatic encryptBlock(input blockT key, input blockT plain, output blockT cipher);
		writeBlock(regAddrT'(`DES_REG_KEY), key);
		writeBlock(regAddrT'(`DES_REG_DATA), plain);
		busWrite(regAddrT'(`DES_REG_START), 32'h1);
		waitReady();
		readResult(cipher);
	endtask

	task automatic resetDefaults();
		busWordT word;
		busRead(regAddrT'(`DES_REG_STATUS), word);
		checkEq(word, 64'h1, "STATUS after reset");
		busRead(regAddrT'(`DES_REG_DATA), word);
		checkEq(word, 64'h0, "DATA low word after reset");
		busRead(regAddrT'(`DES_REG_DATA), word);
		checkEq(word, 64'h0, "DATA high word after reset");
		// The key register holds a nonzero word here, yet its slot must still read zero.
		busWrite(regAddrT'(`DES_REG_KEY), 32'hA5C3_5A3C);
		busRead(regAddrT'(`DES_REG_KEY), word);
		checkEq(word, 64'h0, "KEY slot read");
		busRead(regAddrT'(`DES_REG_START), word);
		checkEq(word, 64'h0, "START slot read");
	endtask

	task automatic knownVector(input blockT key, input blockT plain, input blockT expected);
		blockT cipher;
		encryptBlock(key, plain, cipher);
		checkEq(cipher, expected, "Known-answer ciphertext");
	endtask

	// DES satisfies E(~k, ~p) == ~E(k, p).
	task automatic complementProperty(input int runs);
		blockT key;
		blockT plain;
		blockT cipher;
		blockT cipherInv;
		for (int n = 0; n < runs; n++)
		begin
			key = randomBlock();
			plain = randomBlock();
			encryptBlock(key, plain, cipher);
			encryptBlock(~key, ~plain, cipherInv);
			checkEq(cipherInv, ~cipher, "Ciphertext of complemented inputs");
		end
	endtask

	task automatic restartMidRun();
		busWordT status;
		blockT cipher;
		writeBlock(regAddrT'(`DES_REG_KEY), 64'h133457799BBCDFF1);
		writeBlock(regAddrT'(`DES_REG_DATA), 64'h0);
		busWrite(regAddrT'(`DES_REG_START), 32'h1);
		busRead(regAddrT'(`DES_REG_STATUS), status);
		checkEq(status, 64'h0, "STATUS right after START");
		writeBlock(regAddrT'(`DES_REG_DATA), 64'h0123456789ABCDEF);
		busRead(regAddrT'(`DES_REG_STATUS), status);
		checkEq(status, 64'h0, "STATUS before the second START");
		// The first run is still in its rounds here.
		busWrite(regAddrT'(`DES_REG_START), 32'h1);
		busRead(regAddrT'(`DES_REG_STATUS), status);
		checkEq(status, 64'h0, "STATUS right after the second START");
		waitReady();
		readResult(cipher);
		checkEq(cipher, 64'h85E813540F0AB405, "Ciphertext after a restart");
	endtask

	initial
	begin
		RD = 1'b0;
		WR = 1'b0;
		Addr = '0;
		DataIn = '0;
		rstN = 1'b0;
		lfsrState = 32'h65a0512d;
		repeat (3) @(posedge Clk);
		rstN <= 1'b1;

		resetDefaults();
		knownVector(64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 64'h85E813540F0AB405);
		knownVector(64'h0, 64'h0, 64'h8CA64DE9C1B123A7);
		complementProperty(4);
		restartMidRun();

		$display("TEST OK");
		$finish;
	end

endmodule
